// File: rtl/sdcard_pkg.sv
/* shared types for the sd card reader: user commands, card type,
   controller states, sd command indices, frame layout and frame builder */
package sdcard_pkg;

  // user side command, sampled by the sector buffer
  typedef enum logic [1:0] {
    cmd_idle = 2'd0,
    cmd_read = 2'd1,
    cmd_next = 2'd2
  } user_cmd_e;

  // card type as decided during initialization
  typedef enum logic [1:0] {
    type_unknown = 2'd0,
    type_sdv1    = 2'd1,
    type_sdv2    = 2'd2,
    type_sdhc    = 2'd3
  } card_type_e;

  // controller state, also visible on the top level
  typedef enum logic [3:0] {
    st_power_up   = 4'd0,
    st_cmd0       = 4'd1,
    st_cmd8       = 4'd2,
    st_cmd55      = 4'd3,
    st_acmd41     = 4'd4,
    st_cmd58      = 4'd5,
    st_ready      = 4'd6,
    st_cmd17      = 4'd7,
    st_wait_token = 4'd8,
    st_data       = 4'd9,
    st_crc        = 4'd10,
    st_error      = 4'd11
  } card_stat_e;

  localparam int sector_bytes = 512;
  // start block token ahead of the data bytes
  localparam logic [7:0] data_token = 8'hFE;

  // command indices used in spi mode
  localparam logic [5:0] cmd_go_idle       = 6'd0;
  localparam logic [5:0] cmd_send_if_cond  = 6'd8;
  localparam logic [5:0] cmd_read_single   = 6'd17;
  localparam logic [5:0] acmd_send_op_cond = 6'd41;
  localparam logic [5:0] cmd_app           = 6'd55;
  localparam logic [5:0] cmd_read_ocr      = 6'd58;

  // 2.7-3.6 V range plus check pattern
  localparam logic [31:0] if_cond_arg = 32'h0000_01AA;
  // hcs bit set, host supports high capacity
  localparam logic [31:0] op_cond_arg = 32'h4000_0000;

  // crc7 only checked for cmd0 and cmd8 in spi mode
  localparam logic [6:0] crc7_cmd0  = 7'h4A;
  localparam logic [6:0] crc7_cmd8  = 7'h43;
  localparam logic [6:0] crc7_dummy = 7'h00;

  // 48-bit frame, sent msb first
  typedef struct packed {
    logic [1:0]  start;
    logic [5:0]  index;
    logic [31:0] arg;
    logic [7:0]  crc_end;
  } sd_cmd_t;

  function automatic sd_cmd_t build_cmd(logic [5:0] index, logic [31:0] arg, logic [6:0] crc7);
    sd_cmd_t frame;
    // start bit 0, transmission bit 1
    frame.start   = 2'b01;
    frame.index   = index;
    frame.arg     = arg;
    // stop bit closes the frame
    frame.crc_end = {crc7, 1'b1};
    return frame;
  endfunction

endpackage

// File: rtl/sd_ifs.sv
/* spi_byte_if between controller and spi engine,
   sector_read_if between controller and sector buffer */
`timescale 1ns/1ps

interface spi_byte_if;
  // one byte exchange per start pulse
  logic       start;
  logic [7:0] tx_byte;
  logic       cs_n;
  // done pulses with rx_byte valid
  logic       done;
  logic [7:0] rx_byte;

  modport master (output start, output tx_byte, output cs_n, input done, input rx_byte);
  modport slave (input start, input tx_byte, input cs_n, output done, output rx_byte);
endinterface

interface sector_read_if;
  // read request from the buffer
  logic        rstart;
  logic [31:0] rsector;
  // rbusy also covers card initialization
  logic        rbusy;
  logic        rdone;
  // byte stream of the sector
  logic        outen;
  logic [8:0]  outaddr;
  logic [7:0]  outbyte;

  modport src (
    input rstart, input rsector,
    output rbusy, output rdone, output outen, output outaddr, output outbyte
  );
  modport dst (
    output rstart, output rsector,
    input rbusy, input rdone, input outen, input outaddr, input outbyte
  );
endinterface

// File: rtl/sd_spi_phy.sv
/* spi mode-0 byte engine with clock divider,
   msb first, mosi idles high and sclk idles low */
`timescale 1ns/1ps

module sd_spi_phy #(
  parameter int clk_div = 2
) (
  input  logic       clk,
  input  logic       rst_n,
  spi_byte_if.slave  spi,
  output logic       sd_clk_o,
  output logic       sd_mosi_o,
  output logic       sd_cs_n_o,
  input  logic       sd_miso_i
);

  localparam int cnt_w = (clk_div > 1) ? $clog2(clk_div) : 1;

  logic             busy;
  logic [cnt_w-1:0] div_cnt;
  logic [2:0]       bit_cnt;
  logic [7:0]       tx_sr;
  logic [7:0]       rx_sr;
  logic             tick;

  // half period elapsed, toggle sclk
  assign tick = busy && (div_cnt == cnt_w'(clk_div - 1));
  assign spi.rx_byte = rx_sr;
  // chip select level comes straight from the controller
  assign sd_cs_n_o = spi.cs_n;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      sd_clk_o  <= 1'b0;
      sd_mosi_o <= 1'b1;
      spi.done  <= 1'b0;
    end else begin
      spi.done <= 1'b0;
      if (!busy) begin
        if (spi.start) begin
          busy      <= 1'b1;
          div_cnt   <= '0;
          bit_cnt   <= '0;
          // first bit must be ready before the first rising edge
          sd_mosi_o <= spi.tx_byte[7];
        end
      end else if (tick) begin
        div_cnt  <= '0;
        sd_clk_o <= !sd_clk_o;
        if (sd_clk_o) begin
          // falling edge, move to the next bit
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) begin
            busy      <= 1'b0;
            spi.done  <= 1'b1;
            sd_mosi_o <= 1'b1;
          end else begin
            sd_mosi_o <= tx_sr[7];
          end
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // shift registers for the byte in flight
  always_ff @(posedge clk) begin
    if (!busy && spi.start) begin
      tx_sr <= {spi.tx_byte[6:0], 1'b1};
    end else if (tick && sd_clk_o) begin
      tx_sr <= {tx_sr[6:0], 1'b1};
    end
    // sample miso on the rising edge
    if (tick && !sd_clk_o) begin
      rx_sr <= {rx_sr[6:0], sd_miso_i};
    end
  end

endmodule

// File: rtl/sd_card_ctrl.sv
/* sd card controller in spi mode: power-up clocks, card identification
   (cmd0, cmd8, cmd55/acmd41, cmd58) and single block read with cmd17 */
`timescale 1ns/1ps

module sd_card_ctrl import sdcard_pkg::*; #(
  parameter int fast_init = 0
) (
  input  logic        clk,
  input  logic        rst_n,
  sector_read_if.src  rd,
  spi_byte_if.master  spi,
  output card_stat_e  card_stat_o,
  output card_type_e  card_type_o
);

  // 1 ms at a 100 MHz system clock before the 80 idle clocks
  localparam int pwr_wait_cycles = (fast_init != 0) ? 0 : 100_000;
  localparam int pwr_bytes       = 10;
  localparam int poll_limit      = 8;
  localparam int token_limit     = 1024;
  localparam int acmd41_limit    = 1024;

  // progress within one command exchange
  typedef enum logic [1:0] {
    ph_cmd,
    ph_resp,
    ph_extra
  } phase_e;

  card_stat_e  stat;
  card_type_e  ctype;
  phase_e      phase;
  logic [47:0] frame_q;
  logic [8:0]  byte_cnt;
  logic [9:0]  poll_cnt;
  logic [9:0]  retry_cnt;
  logic [16:0] wait_cnt;
  logic        waiting;
  logic [7:0]  r1_q;
  logic [31:0] extra_q;
  logic        xfer_en;
  logic        fin;
  logic [7:0]  fin_r1;
  logic [31:0] fin_ext;
  logic [31:0] card_addr;

  assign card_stat_o = stat;
  assign card_type_o = ctype;
  // frame bytes while sending a command, otherwise clock out ones
  assign spi.tx_byte = (phase == ph_cmd) ? frame_q[47:40] : 8'hFF;
  // standard capacity cards take a byte address
  assign card_addr = (ctype == type_sdhc) ? rd.rsector : {rd.rsector[22:0], 9'd0};

  always_comb begin
    xfer_en = 1'b1;
    if (stat == st_ready || stat == st_error) begin
      xfer_en = 1'b0;
    end
    if (stat == st_power_up && wait_cnt != '0) begin
      xfer_en = 1'b0;
    end
  end

  // complete response seen, r1 alone or r1 plus 4 trailing bytes
  always_comb begin
    fin     = 1'b0;
    fin_r1  = spi.rx_byte;
    fin_ext = {extra_q[23:0], spi.rx_byte};
    if (spi.done && stat inside {st_cmd0, st_cmd8, st_cmd55, st_acmd41, st_cmd58, st_cmd17}) begin
      if (phase == ph_resp && !spi.rx_byte[7] && !(stat inside {st_cmd8, st_cmd58})) begin
        fin = 1'b1;
      end
      if (phase == ph_extra && byte_cnt == 9'd3) begin
        fin    = 1'b1;
        fin_r1 = r1_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stat      <= st_power_up;
      ctype     <= type_unknown;
      phase     <= ph_resp;
      frame_q   <= '1;
      byte_cnt  <= '0;
      poll_cnt  <= '0;
      retry_cnt <= '0;
      wait_cnt  <= 17'(pwr_wait_cycles);
      waiting   <= 1'b0;
      spi.start <= 1'b0;
      spi.cs_n  <= 1'b1;
      rd.rbusy  <= 1'b1;
      rd.rdone  <= 1'b0;
      rd.outen  <= 1'b0;
    end else begin
      spi.start <= 1'b0;
      rd.rdone  <= 1'b0;
      rd.outen  <= 1'b0;
      if (stat == st_power_up && wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      if (stat == st_error) begin
        spi.cs_n <= 1'b1;
      end
      // one byte in flight at a time
      if (xfer_en && !waiting) begin
        spi.start <= 1'b1;
        waiting   <= 1'b1;
      end

      if (spi.done) begin
        waiting <= 1'b0;
        case (stat)
          st_power_up: begin
            // idle clocks with cs high, then cmd0
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 9'(pwr_bytes - 1)) begin
              spi.cs_n <= 1'b0;
              frame_q  <= build_cmd(cmd_go_idle, 32'd0, crc7_cmd0);
              phase    <= ph_cmd;
              byte_cnt <= '0;
              stat     <= st_cmd0;
            end
          end
          st_wait_token: begin
            if (spi.rx_byte == data_token) begin
              stat     <= st_data;
              byte_cnt <= '0;
            end else if (spi.rx_byte != 8'hFF || poll_cnt == 10'(token_limit - 1)) begin
              // error token or no token at all
              stat <= st_error;
            end else begin
              poll_cnt <= poll_cnt + 1'b1;
            end
          end
          st_data: begin
            rd.outen <= 1'b1;
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 9'(sector_bytes - 1)) begin
              byte_cnt <= '0;
              stat     <= st_crc;
            end
          end
          st_crc: begin
            // two crc bytes, read and dropped
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 9'd1) begin
              stat     <= st_ready;
              spi.cs_n <= 1'b1;
              rd.rbusy <= 1'b0;
              rd.rdone <= 1'b1;
            end
          end
          default: begin
            case (phase)
              ph_cmd: begin
                frame_q  <= {frame_q[39:0], 8'hFF};
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == 9'd5) begin
                  phase    <= ph_resp;
                  poll_cnt <= '0;
                end
              end
              ph_resp: begin
                // r1 starts with a zero msb
                if (spi.rx_byte[7]) begin
                  if (poll_cnt == 10'(poll_limit - 1)) begin
                    stat <= st_error;
                  end else begin
                    poll_cnt <= poll_cnt + 1'b1;
                  end
                end else if (stat inside {st_cmd8, st_cmd58}) begin
                  phase    <= ph_extra;
                  byte_cnt <= '0;
                end
              end
              default: begin
                byte_cnt <= byte_cnt + 1'b1;
              end
            endcase
          end
        endcase
      end

      if (fin) begin
        phase    <= ph_cmd;
        byte_cnt <= '0;
        case (stat)
          st_cmd0: begin
            if (fin_r1 == 8'h01) begin
              frame_q <= build_cmd(cmd_send_if_cond, if_cond_arg, crc7_cmd8);
              stat    <= st_cmd8;
            end else begin
              stat <= st_error;
            end
          end
          st_cmd8: begin
            // valid r7 echo marks a v2 card, v1 cards are not handled
            if (fin_r1 == 8'h01 && fin_ext[11:0] == if_cond_arg[11:0]) begin
              ctype   <= type_sdv2;
              frame_q <= build_cmd(cmd_app, 32'd0, crc7_dummy);
              stat    <= st_cmd55;
            end else begin
              stat <= st_error;
            end
          end
          st_cmd55: begin
            if (fin_r1[7:1] == 7'd0) begin
              frame_q <= build_cmd(acmd_send_op_cond, op_cond_arg, crc7_dummy);
              stat    <= st_acmd41;
            end else begin
              stat <= st_error;
            end
          end
          st_acmd41: begin
            if (fin_r1 == 8'h00) begin
              frame_q <= build_cmd(cmd_read_ocr, 32'd0, crc7_dummy);
              stat    <= st_cmd58;
            end else if (fin_r1 == 8'h01 && retry_cnt != 10'(acmd41_limit - 1)) begin
              // card still in idle, go round again
              retry_cnt <= retry_cnt + 1'b1;
              frame_q   <= build_cmd(cmd_app, 32'd0, crc7_dummy);
              stat      <= st_cmd55;
            end else begin
              stat <= st_error;
            end
          end
          st_cmd58: begin
            if (fin_r1 == 8'h00) begin
              // ccs bit of the ocr
              ctype    <= fin_ext[30] ? type_sdhc : type_sdv2;
              phase    <= ph_resp;
              spi.cs_n <= 1'b1;
              rd.rbusy <= 1'b0;
              stat     <= st_ready;
            end else begin
              stat <= st_error;
            end
          end
          st_cmd17: begin
            if (fin_r1 == 8'h00) begin
              phase    <= ph_resp;
              poll_cnt <= '0;
              stat     <= st_wait_token;
            end else begin
              stat <= st_error;
            end
          end
          default: begin
            stat <= st_error;
          end
        endcase
      end

      // new read request from the buffer
      if (stat == st_ready && rd.rstart) begin
        frame_q  <= build_cmd(cmd_read_single, card_addr, crc7_dummy);
        phase    <= ph_cmd;
        byte_cnt <= '0;
        spi.cs_n <= 1'b0;
        rd.rbusy <= 1'b1;
        stat     <= st_cmd17;
      end
    end
  end

  // received bytes, qualified later by outen, fin and phase
  always_ff @(posedge clk) begin
    if (spi.done) begin
      rd.outbyte <= spi.rx_byte;
      rd.outaddr <= byte_cnt;
      if (phase == ph_resp) begin
        r1_q <= spi.rx_byte;
      end
      if (phase == ph_extra) begin
        extra_q <= {extra_q[23:0], spi.rx_byte};
      end
    end
  end

endmodule

// File: rtl/sector_buffer.sv
/* 512-byte sector store with user command decode,
   busy flag and byte read pointer */
`timescale 1ns/1ps

module sector_buffer import sdcard_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  user_cmd_e    command_i,
  input  logic [31:0]  sector_address_i,
  output logic [7:0]   data_o,
  output logic         busy_o,
  sector_read_if.dst   rd
);

  typedef enum logic [1:0] {
    buf_init,
    buf_idle,
    buf_reading
  } buf_state_e;

  logic [7:0] mem [sector_bytes];
  logic [8:0] ptr;
  buf_state_e state;

  // byte under the read pointer
  assign data_o = mem[ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= buf_init;
      ptr       <= '0;
      busy_o    <= 1'b1;
      rd.rstart <= 1'b0;
    end else begin
      rd.rstart <= 1'b0;
      case (state)
        buf_init: begin
          // wait for the card to finish initialization
          if (!rd.rbusy) begin
            busy_o <= 1'b0;
            state  <= buf_idle;
          end
        end
        buf_idle: begin
          if (command_i == cmd_read) begin
            rd.rstart <= 1'b1;
            ptr       <= '0;
            busy_o    <= 1'b1;
            state     <= buf_reading;
          end else if (command_i == cmd_next) begin
            // wraps from 511 back to 0
            ptr <= ptr + 1'b1;
          end
        end
        default: begin
          // user commands ignored until the sector is complete
          if (rd.rdone) begin
            busy_o <= 1'b0;
            state  <= buf_idle;
          end
        end
      endcase
    end
  end

  // sector number and byte store
  always_ff @(posedge clk) begin
    if (state == buf_idle && command_i == cmd_read) begin
      rd.rsector <= sector_address_i;
    end
    // position taken from the card stream
    if (rd.outen) begin
      mem[rd.outaddr] <= rd.outbyte;
    end
  end

endmodule

// File: rtl/sdcard_top.sv
/* sd card sector reader top level:
   sector buffer, card controller and spi engine */
`timescale 1ns/1ps

module sdcard_top import sdcard_pkg::*; #(
  // spi half period in system clocks
  parameter int clk_div   = 2,
  // short power-up for simulation
  parameter int fast_init = 0
) (
  input  logic        clk,
  input  logic        rst_n,
  input  user_cmd_e   command_i,
  input  logic [31:0] sector_address_i,
  output logic [7:0]  data_o,
  output logic        busy_o,
  output card_stat_e  card_stat_o,
  output card_type_e  card_type_o,
  // card pins
  output logic        sd_clk_o,
  output logic        sd_mosi_o,
  output logic        sd_cs_n_o,
  input  logic        sd_miso_i
);

  spi_byte_if    spi_bus ();
  sector_read_if rd_bus ();

  sector_buffer i_sector_buffer (
    .clk              (clk),
    .rst_n            (rst_n),
    .command_i        (command_i),
    .sector_address_i (sector_address_i),
    .data_o           (data_o),
    .busy_o           (busy_o),
    .rd               (rd_bus.dst)
  );

  sd_card_ctrl #(
    .fast_init (fast_init)
  ) i_sd_card_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd          (rd_bus.src),
    .spi         (spi_bus.master),
    .card_stat_o (card_stat_o),
    .card_type_o (card_type_o)
  );

  sd_spi_phy #(
    .clk_div (clk_div)
  ) i_sd_spi_phy (
    .clk       (clk),
    .rst_n     (rst_n),
    .spi       (spi_bus.slave),
    .sd_clk_o  (sd_clk_o),
    .sd_mosi_o (sd_mosi_o),
    .sd_cs_n_o (sd_cs_n_o),
    .sd_miso_i (sd_miso_i)
  );

endmodule

// File: verif/sd_card_model.sv
/* behavioral spi-mode sd card: answers cmd0, cmd8, cmd55/acmd41, cmd58
   and cmd17, sector data byte k of address a is a + 3k */
`timescale 1ns/1ps

module sd_card_model import sdcard_pkg::*; (
  input  logic       sd_clk_i,
  input  logic       sd_mosi_i,
  input  logic       sd_cs_n_i,
  output logic       sd_miso_o,
  // card flavour, fixed across one power cycle
  input  logic       high_capacity_i,
  input  logic [7:0] acmd41_busy_i
);

  logic [7:0] rx_sr     = 8'hFF;
  logic [7:0] tx_sr     = 8'hFF;
  logic [2:0] bit_cnt   = 3'd0;
  logic [2:0] frame_idx = 3'd0;
  logic [7:0] acmd_left = 8'd0;
  logic [7:0] frame [6];
  // bytes waiting to go out on miso
  logic [7:0] resp_q [$];

  // miso released high while deselected
  assign sd_miso_o = sd_cs_n_i ? 1'b1 : tx_sr[7];

  task automatic answer_cmd(input logic [5:0] index, input logic [31:0] arg);
    logic [31:0] addr;
    int          k;
    // one ncr filler byte ahead of every response
    resp_q.push_back(8'hFF);
    case (index)
      6'd0: begin
        resp_q.push_back(8'h01);
        acmd_left = acmd41_busy_i;
      end
      6'd8: begin
        // r7, voltage and check pattern echoed
        resp_q.push_back(8'h01);
        resp_q.push_back(8'h00);
        resp_q.push_back(8'h00);
        resp_q.push_back(arg[15:8]);
        resp_q.push_back(arg[7:0]);
      end
      6'd55: begin
        resp_q.push_back((acmd_left != 8'd0) ? 8'h01 : 8'h00);
      end
      6'd41: begin
        if (acmd_left != 8'd0) begin
          resp_q.push_back(8'h01);
          acmd_left = acmd_left - 8'd1;
        end else begin
          resp_q.push_back(8'h00);
        end
      end
      6'd58: begin
        // ocr with power-up done, ccs and 2.7-3.6 V window
        resp_q.push_back(8'h00);
        resp_q.push_back({1'b1, high_capacity_i, 6'b0});
        resp_q.push_back(8'hFF);
        resp_q.push_back(8'h80);
        resp_q.push_back(8'h00);
      end
      6'd17: begin
        resp_q.push_back(8'h00);
        // access delay before the token
        repeat (3) resp_q.push_back(8'hFF);
        resp_q.push_back(data_token);
        for (k = 0; k < sector_bytes; k++) begin
          addr = arg + 32'(3 * k);
          resp_q.push_back(addr[7:0]);
        end
        // crc bytes, never checked by the host
        resp_q.push_back(8'hA5);
        resp_q.push_back(8'h5A);
      end
      default: begin
        // illegal command
        resp_q.push_back(8'h04);
      end
    endcase
  endtask

  task automatic take_byte(input logic [7:0] b);
    // a frame starts with bits 01, idle ones are skipped
    if (frame_idx != 3'd0 || b[7:6] == 2'b01) begin
      frame[frame_idx] = b;
      frame_idx = frame_idx + 3'd1;
      if (frame_idx == 3'd6) begin
        frame_idx = 3'd0;
        answer_cmd(frame[0][5:0], {frame[1], frame[2], frame[3], frame[4]});
      end
    end
  endtask

  // mode 0, sample mosi on rising sclk, shift miso on falling sclk
  always @(posedge sd_clk_i or negedge sd_clk_i or posedge sd_cs_n_i) begin
    if (sd_cs_n_i) begin
      bit_cnt   = 3'd0;
      frame_idx = 3'd0;
      tx_sr     = 8'hFF;
      resp_q.delete();
    end else if (sd_clk_i) begin
      rx_sr   = {rx_sr[6:0], sd_mosi_i};
      bit_cnt = bit_cnt + 3'd1;
      if (bit_cnt == 3'd0) begin
        take_byte(rx_sr);
      end
    end else if (bit_cnt == 3'd0) begin
      // byte boundary, next byte with its msb first
      if (resp_q.size() > 0) begin
        tx_sr = resp_q.pop_front();
      end else begin
        tx_sr = 8'hFF;
      end
    end else begin
      tx_sr = {tx_sr[6:0], 1'b1};
    end
  end

endmodule

// File: verif/tb_sdcard_top.sv
/* directed testbench for sdcard_top with an spi-mode card model:
   init, sdhc and standard reads, pointer wrap, busy behaviour */
`timescale 1ns/1ps

module tb_sdcard_top import sdcard_pkg::*; ();

  localparam int init_timeout = 20000;
  localparam int read_timeout = 40000;

  logic        clk;
  logic        rst_n;
  user_cmd_e   command;
  logic [31:0] sector_address;
  logic [7:0]  data;
  logic        busy;
  card_stat_e  card_stat;
  card_type_e  card_type;
  logic        sd_clk;
  logic        sd_mosi;
  logic        sd_cs_n;
  logic        sd_miso;
  logic        high_capacity;
  logic [7:0]  acmd41_busy;
  integer      seed;
  logic [31:0] sec_a;

  sdcard_top #(
    .clk_div   (2),
    .fast_init (1)
  ) i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .command_i        (command),
    .sector_address_i (sector_address),
    .data_o           (data),
    .busy_o           (busy),
    .card_stat_o      (card_stat),
    .card_type_o      (card_type),
    .sd_clk_o         (sd_clk),
    .sd_mosi_o        (sd_mosi),
    .sd_cs_n_o        (sd_cs_n),
    .sd_miso_i        (sd_miso)
  );

  sd_card_model i_card (
    .sd_clk_i        (sd_clk),
    .sd_mosi_i       (sd_mosi),
    .sd_cs_n_i       (sd_cs_n),
    .sd_miso_o       (sd_miso),
    .high_capacity_i (high_capacity),
    .acmd41_busy_i   (acmd41_busy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %02h, expected %02h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_type(input string name, input card_type_e got, input card_type_e exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
      stop_run();
    end
  endtask

  task automatic check_stat(input string name, input card_stat_e got, input card_stat_e exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
      stop_run();
    end
  endtask

  // byte k of card address a
  function automatic logic [7:0] expected_byte(input logic [31:0] a, input int k);
    logic [31:0] v;
    v = a + 32'(3 * k);
    return v[7:0];
  endfunction

  task automatic apply_reset(input logic hc, input logic [7:0] busy_polls);
    @(posedge clk);
    rst_n         <= 1'b0;
    command       <= cmd_idle;
    high_capacity <= hc;
    acmd41_busy   <= busy_polls;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // returns on the first falling clock with busy_o low
  task automatic wait_idle(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (busy && n < max_cycles) begin
      n++;
      @(negedge clk);
    end
    if (busy) begin
      $display("busy_o still high after %0d cycles at %0t", max_cycles, $time);
      stop_run();
    end
  endtask

  task automatic issue_read(input logic [31:0] s);
    @(posedge clk);
    command        <= cmd_read;
    sector_address <= s;
    @(posedge clk);
    command <= cmd_idle;
    // busy one cycle after the sampled read
    @(negedge clk);
    check_bit("busy_o", busy, 1'b1);
  endtask

  task automatic read_sector(input logic [31:0] s);
    issue_read(s);
    wait_idle(read_timeout);
  endtask

  // one cmd_next, new byte visible the cycle after
  task automatic step_byte();
    @(posedge clk);
    command <= cmd_next;
    @(posedge clk);
    command <= cmd_idle;
    @(negedge clk);
  endtask

  task automatic check_sector(input logic [31:0] a);
    int k;
    check_byte("data_o", data, expected_byte(a, 0));
    for (k = 1; k < sector_bytes; k++) begin
      step_byte();
      check_byte("data_o", data, expected_byte(a, k));
    end
  endtask

  task automatic test_reset_and_init();
    apply_reset(1'b1, 8'd3);
    @(negedge clk);
    check_bit("busy_o", busy, 1'b1);
    check_type("card_type_o", card_type, type_unknown);
    check_stat("card_stat_o", card_stat, st_power_up);
    // card deselected, clock low and mosi high out of reset
    check_bit("sd_cs_n_o", sd_cs_n, 1'b1);
    check_bit("sd_mosi_o", sd_mosi, 1'b1);
    check_bit("sd_clk_o", sd_clk, 1'b0);
    wait_idle(init_timeout);
    check_type("card_type_o", card_type, type_sdhc);
    check_stat("card_stat_o", card_stat, st_ready);
  endtask

  task automatic test_sdhc_read(output logic [31:0] s);
    s = $random(seed);
    read_sector(s);
    check_sector(s);
  endtask

  // pointer sits on byte 511 here
  task automatic test_pointer_wrap(input logic [31:0] s);
    step_byte();
    check_byte("data_o", data, expected_byte(s, 0));
  endtask

  task automatic test_busy_ignores_commands();
    logic [31:0] s1;
    logic [31:0] s2;
    s1 = $random(seed);
    s2 = s1 ^ 32'h0000_00A5;
    issue_read(s1);
    repeat (8) @(posedge clk);
    command        <= cmd_read;
    sector_address <= s2;
    @(posedge clk);
    command <= cmd_next;
    @(posedge clk);
    command <= cmd_idle;
    @(negedge clk);
    check_bit("busy_o", busy, 1'b1);
    wait_idle(read_timeout);
    check_sector(s1);
  endtask

  task automatic test_back_to_back();
    logic [31:0] s1;
    logic [31:0] s2;
    s1 = $random(seed);
    s2 = s1 ^ 32'h0000_003C;
    read_sector(s1);
    check_sector(s1);
    read_sector(s2);
    check_sector(s2);
  endtask

  task automatic test_standard_card();
    logic [31:0] r;
    logic [31:0] s;
    apply_reset(1'b0, 8'd2);
    wait_idle(init_timeout);
    check_type("card_type_o", card_type, type_sdv2);
    r = $random(seed);
    // sector small enough for a 32-bit byte address
    s = {9'd0, r[22:0]};
    read_sector(s);
    check_sector(s << 9);
  endtask

  initial begin
    seed           = 93;
    rst_n          = 1'b0;
    command        = cmd_idle;
    sector_address = 32'd0;
    high_capacity  = 1'b1;
    acmd41_busy    = 8'd0;
    test_reset_and_init();
    test_sdhc_read(sec_a);
    test_pointer_wrap(sec_a);
    test_busy_ignores_commands();
    test_back_to_back();
    test_standard_card();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: list.f
rtl/sdcard_pkg.sv
rtl/sd_ifs.sv
rtl/sd_spi_phy.sv
rtl/sd_card_ctrl.sv
rtl/sector_buffer.sv
rtl/sdcard_top.sv
verif/sd_card_model.sv
verif/tb_sdcard_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the sd card reader testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 -f list.f --top-module tb_sdcard_top -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
